//--- tower_cfg.svh
`ifndef TOWER_CFG_SVH
`define TOWER_CFG_SVH

// map geometry
`define GRID_W 16
`define FLOORS 4

`define COORD_W 4
`define FLOOR_W 2

// floor on top, then y, then x
`define ADDR_W (`FLOOR_W + 2 * `COORD_W)

`define TILE_W 4

// player stats
`define HEALTH_W 16
`define KEYS_W 8

`define INIT_HEALTH 100
`define MONSTER_DAMAGE 30

// spawn cell on floor 0
`define START_X 1
`define START_Y 1

`endif

//--- tile_pkg.sv
`default_nettype none

`include "tower_cfg.svh"

package tile_pkg;

  // one cell coordinate on the grid
  typedef logic [`COORD_W-1:0] coord_t;

  // {floor, y, x}
  typedef logic [`ADDR_W-1:0] map_addr_t;

  // tile codes as stored in the map RAM
  typedef enum logic [`TILE_W-1:0] {
    tile_floor   = 4'd0,
    tile_wall    = 4'd1,
    tile_key     = 4'd2,
    tile_door    = 4'd3,
    tile_monster = 4'd4,
    tile_stairs  = 4'd5
  } tile_t;

endpackage

`default_nettype wire

//--- player_pkg.sv
`default_nettype none

`include "tower_cfg.svh"

package player_pkg;

  typedef enum logic [2:0] {
    dir_none,
    dir_left,
    dir_down,
    dir_up,
    dir_right
  } dir_t;

  typedef logic [`HEALTH_W-1:0] health_t;
  typedef logic [`KEYS_W-1:0]   keys_t;
  typedef logic [`FLOOR_W-1:0]  floor_t;

  // interaction sequence
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_decide
  } act_state_t;

  // what a move does to the player
  typedef enum logic [2:0] {
    out_move,
    out_take_key,
    out_open_door,
    out_fight,
    out_climb,
    out_blocked
  } outcome_t;

endpackage

`default_nettype wire

//--- move_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "tower_cfg.svh"

module move_decode (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire [3:0]             kbd,
  input  wire                   busy,
  input  wire tile_pkg::coord_t player_x,
  input  wire tile_pkg::coord_t player_y,
  output logic                  move,
  output tile_pkg::coord_t      target_x,
  output tile_pkg::coord_t      target_y
);

  logic [3:0]       kbd_q;
  logic [3:0]       kbd_qq;
  logic [3:0]       rise;
  player_pkg::dir_t dir;
  tile_pkg::coord_t nx;
  tile_pkg::coord_t ny;
  logic             step_ok;

  // kbd is {right, up, down, left}
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kbd_q  <= '0;
      kbd_qq <= '0;
    end else begin
      kbd_q  <= kbd;
      kbd_qq <= kbd_q;
    end
  end

  assign rise = kbd_q & ~kbd_qq;

  // left wins, then down, up, right
  always_comb begin
    if (rise[0]) begin
      dir = player_pkg::dir_left;
    end else if (rise[1]) begin
      dir = player_pkg::dir_down;
    end else if (rise[2]) begin
      dir = player_pkg::dir_up;
    end else if (rise[3]) begin
      dir = player_pkg::dir_right;
    end else begin
      dir = player_pkg::dir_none;
    end
  end

  // neighbour cell, no wrap at the edges
  always_comb begin
    nx      = player_x;
    ny      = player_y;
    step_ok = 1'b0;
    case (dir)
      player_pkg::dir_left: begin
        step_ok = (player_x != '0);
        nx      = player_x - 1'b1;
      end
      player_pkg::dir_right: begin
        step_ok = (player_x != tile_pkg::coord_t'(`GRID_W - 1));
        nx      = player_x + 1'b1;
      end
      player_pkg::dir_up: begin
        step_ok = (player_y != '0);
        ny      = player_y - 1'b1;
      end
      player_pkg::dir_down: begin
        step_ok = (player_y != tile_pkg::coord_t'(`GRID_W - 1));
        ny      = player_y + 1'b1;
      end
      default: begin
        step_ok = 1'b0;
      end
    endcase
  end

  // presses during busy are lost
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      move <= 1'b0;
    end else begin
      move <= step_ok & ~busy;
    end
  end

  always_ff @(posedge clk) begin
    target_x <= nx;
    target_y <= ny;
  end

endmodule

`default_nettype wire

//--- tile_interact.sv
`timescale 1ns/100ps
`default_nettype none

`include "tower_cfg.svh"

module tile_interact (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     move,
  input  wire tile_pkg::coord_t   target_x,
  input  wire tile_pkg::coord_t   target_y,
  input  wire player_pkg::floor_t floor,
  input  wire player_pkg::health_t health,
  input  wire player_pkg::keys_t  key_num,
  input  wire tile_pkg::tile_t    rd_tile,
  output logic                    busy,
  output tile_pkg::map_addr_t     rd_addr,
  output logic                    wr_en,
  output tile_pkg::map_addr_t     wr_addr,
  output tile_pkg::tile_t         wr_tile,
  output logic                    apply,
  output player_pkg::outcome_t    outcome,
  output tile_pkg::coord_t        new_x,
  output tile_pkg::coord_t        new_y
);

  player_pkg::act_state_t state;
  player_pkg::act_state_t state_nxt;
  tile_pkg::coord_t       tx_q;
  tile_pkg::coord_t       ty_q;
  tile_pkg::map_addr_t    held_addr;
  logic                   clear_tile;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= player_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      player_pkg::st_idle: begin
        if (move) begin
          state_nxt = player_pkg::st_read;
        end
      end
      player_pkg::st_read: begin
        state_nxt = player_pkg::st_decide;
      end
      default: begin
        state_nxt = player_pkg::st_idle;
      end
    endcase
  end

  // hold the target for the rest of the sequence
  always_ff @(posedge clk) begin
    if (state == player_pkg::st_idle && move) begin
      tx_q <= target_x;
      ty_q <= target_y;
    end
  end

  assign held_addr = {floor, ty_q, tx_q};

  // read goes out in the move cycle, address is then held
  assign rd_addr = (state == player_pkg::st_idle) ? {floor, target_y, target_x} : held_addr;

  assign busy = move | (state != player_pkg::st_idle);

  // game rules
  always_comb begin
    outcome    = player_pkg::out_blocked;
    clear_tile = 1'b0;
    case (rd_tile)
      tile_pkg::tile_floor: begin
        outcome = player_pkg::out_move;
      end
      tile_pkg::tile_key: begin
        outcome    = player_pkg::out_take_key;
        clear_tile = 1'b1;
      end
      tile_pkg::tile_door: begin
        if (key_num != '0) begin
          outcome    = player_pkg::out_open_door;
          clear_tile = 1'b1;
        end
      end
      tile_pkg::tile_monster: begin
        // only fights that leave the player alive
        if (health > player_pkg::health_t'(`MONSTER_DAMAGE)) begin
          outcome    = player_pkg::out_fight;
          clear_tile = 1'b1;
        end
      end
      tile_pkg::tile_stairs: begin
        if (floor < player_pkg::floor_t'(`FLOORS - 1)) begin
          outcome = player_pkg::out_climb;
        end
      end
      default: begin
        outcome = player_pkg::out_blocked;
      end
    endcase
  end

  assign apply   = (state == player_pkg::st_decide);
  assign wr_en   = apply & clear_tile;
  assign wr_addr = held_addr;
  assign wr_tile = tile_pkg::tile_floor;
  assign new_x   = tx_q;
  assign new_y   = ty_q;

endmodule

`default_nettype wire

//--- player_stats.sv
`timescale 1ns/100ps
`default_nettype none

`include "tower_cfg.svh"

module player_stats (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       apply,
  input  wire player_pkg::outcome_t outcome,
  input  wire tile_pkg::coord_t     new_x,
  input  wire tile_pkg::coord_t     new_y,
  output tile_pkg::coord_t          player_x,
  output tile_pkg::coord_t          player_y,
  output player_pkg::health_t       health,
  output player_pkg::keys_t         key_num,
  output player_pkg::floor_t        floor
);

  logic step;

  // every outcome but climb and blocked moves the player
  always_comb begin
    case (outcome)
      player_pkg::out_move,
      player_pkg::out_take_key,
      player_pkg::out_open_door,
      player_pkg::out_fight: begin
        step = 1'b1;
      end
      default: begin
        step = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      player_x <= tile_pkg::coord_t'(`START_X);
      player_y <= tile_pkg::coord_t'(`START_Y);
      health   <= player_pkg::health_t'(`INIT_HEALTH);
      key_num  <= '0;
      floor    <= '0;
    end else if (apply) begin
      if (step) begin
        player_x <= new_x;
        player_y <= new_y;
      end
      case (outcome)
        player_pkg::out_take_key: begin
          key_num <= key_num + 1'b1;
        end
        player_pkg::out_open_door: begin
          key_num <= key_num - 1'b1;
        end
        player_pkg::out_fight: begin
          health <= health - player_pkg::health_t'(`MONSTER_DAMAGE);
        end
        player_pkg::out_climb: begin
          // same x and y on the floor above
          floor <= floor + 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- map_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "tower_cfg.svh"

module map_ram (
  input  wire                      clk,
  input  wire tile_pkg::map_addr_t rd_addr,
  input  wire                      wr_en,
  input  wire tile_pkg::map_addr_t wr_addr,
  input  wire tile_pkg::tile_t     wr_tile,
  input  wire                      load_we,
  input  wire tile_pkg::map_addr_t load_addr,
  input  wire tile_pkg::tile_t     load_tile,
  output tile_pkg::tile_t          rd_tile
);

  localparam int DEPTH = `FLOORS * `GRID_W * `GRID_W;

  // all floors back to back
  tile_pkg::tile_t mem [0:DEPTH-1];

  // load port wins
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_tile;
    end else if (wr_en) begin
      mem[wr_addr] <= wr_tile;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rd_tile <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- tower_core.sv
`timescale 1ns/100ps
`default_nettype none

module tower_core (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire [3:0]                kbd,
  input  wire                      load_we,
  input  wire tile_pkg::map_addr_t load_addr,
  input  wire tile_pkg::tile_t     load_tile,
  output logic                     busy,
  output tile_pkg::coord_t         player_x,
  output tile_pkg::coord_t         player_y,
  output player_pkg::health_t      health,
  output player_pkg::keys_t        key_num,
  output player_pkg::floor_t       floor
);

  logic                 move;
  tile_pkg::coord_t     target_x;
  tile_pkg::coord_t     target_y;
  tile_pkg::map_addr_t  rd_addr;
  tile_pkg::tile_t      rd_tile;
  logic                 wr_en;
  tile_pkg::map_addr_t  wr_addr;
  tile_pkg::tile_t      wr_tile;
  logic                 apply;
  player_pkg::outcome_t outcome;
  tile_pkg::coord_t     new_x;
  tile_pkg::coord_t     new_y;

  move_decode u_move_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .kbd      (kbd),
    .busy     (busy),
    .player_x (player_x),
    .player_y (player_y),
    .move     (move),
    .target_x (target_x),
    .target_y (target_y)
  );

  tile_interact u_tile_interact (
    .clk      (clk),
    .rst_n    (rst_n),
    .move     (move),
    .target_x (target_x),
    .target_y (target_y),
    .floor    (floor),
    .health   (health),
    .key_num  (key_num),
    .rd_tile  (rd_tile),
    .busy     (busy),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_tile  (wr_tile),
    .apply    (apply),
    .outcome  (outcome),
    .new_x    (new_x),
    .new_y    (new_y)
  );

  // stats go out to the display side
  player_stats u_player_stats (
    .clk      (clk),
    .rst_n    (rst_n),
    .apply    (apply),
    .outcome  (outcome),
    .new_x    (new_x),
    .new_y    (new_y),
    .player_x (player_x),
    .player_y (player_y),
    .health   (health),
    .key_num  (key_num),
    .floor    (floor)
  );

  map_ram u_map_ram (
    .clk       (clk),
    .rd_addr   (rd_addr),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_tile   (wr_tile),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_tile (load_tile),
    .rd_tile   (rd_tile)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 100 ns period
  localparam int half_period = 50;

  initial begin
    clk = 1'b0;
  end

  always #half_period clk = ~clk;

endmodule

`default_nettype wire

//--- tower_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tower_cfg.svh"

module tower_tb;

  // about 1030 cycles of map clear plus some 450 for the tests
  localparam int max_cycles = 2000;

  logic                clk;
  logic                rst_n;
  logic [3:0]          kbd;
  logic                load_we;
  tile_pkg::map_addr_t load_addr;
  tile_pkg::tile_t     load_tile;
  logic                busy;
  tile_pkg::coord_t    player_x;
  tile_pkg::coord_t    player_y;
  player_pkg::health_t health;
  player_pkg::keys_t   key_num;
  player_pkg::floor_t  floor;

  int                  cycle_count = 0;
  tile_pkg::coord_t    exp_x;
  tile_pkg::coord_t    exp_y;

  tb_clock u_clock (
    .clk (clk)
  );

  tower_core u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .kbd       (kbd),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_tile (load_tile),
    .busy      (busy),
    .player_x  (player_x),
    .player_y  (player_y),
    .health    (health),
    .key_num   (key_num),
    .floor     (floor)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run went past %0d clock cycles", max_cycles);
      $display("Something failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "check failed");
  endtask

  task automatic check_coord(input string name, input tile_pkg::coord_t got,
                             input tile_pkg::coord_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_health(input player_pkg::health_t got, input player_pkg::health_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED health: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_keys(input player_pkg::keys_t got, input player_pkg::keys_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED key_num: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_floor(input player_pkg::floor_t got, input player_pkg::floor_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED floor: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_position(input tile_pkg::coord_t x, input tile_pkg::coord_t y);
    check_coord("player_x", player_x, x);
    check_coord("player_y", player_y, y);
  endtask

  // inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // kbd is {right, up, down, left}
  function automatic logic [3:0] dir_to_kbd(input player_pkg::dir_t d);
    case (d)
      player_pkg::dir_left:  return 4'b0001;
      player_pkg::dir_down:  return 4'b0010;
      player_pkg::dir_up:    return 4'b0100;
      player_pkg::dir_right: return 4'b1000;
      default:               return 4'b0000;
    endcase
  endfunction

  task automatic apply_reset();
    rst_n   = 1'b0;
    kbd     = 4'b0000;
    load_we = 1'b0;
    repeat (5) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    exp_x = tile_pkg::coord_t'(`START_X);
    exp_y = tile_pkg::coord_t'(`START_Y);
  endtask

  task automatic load_cell(input player_pkg::floor_t fl, input tile_pkg::coord_t x,
                           input tile_pkg::coord_t y, input tile_pkg::tile_t t);
    load_we   = 1'b1;
    load_addr = {fl, y, x};
    load_tile = t;
    next_cycle();
    load_we = 1'b0;
  endtask

  task automatic clear_map();
    for (int a = 0; a < `FLOORS * `GRID_W * `GRID_W; a++) begin
      load_we   = 1'b1;
      load_addr = tile_pkg::map_addr_t'(a);
      load_tile = tile_pkg::tile_floor;
      next_cycle();
    end
    load_we = 1'b0;
  endtask

  // hold the keys one cycle, then wait until the move has finished
  task automatic press_keys(input logic [3:0] mask);
    kbd = mask;
    next_cycle();
    kbd = 4'b0000;
    next_cycle();
    while (busy) begin
      next_cycle();
    end
  endtask

  task automatic press(input player_pkg::dir_t d);
    press_keys(dir_to_kbd(d));
  endtask

  // second key rises while the first move is still in flight
  task automatic press_during_busy(input player_pkg::dir_t first,
                                   input player_pkg::dir_t second);
    kbd = dir_to_kbd(first);
    next_cycle();
    kbd = 4'b0000;
    next_cycle();
    if (!busy) begin
      stop_with_failure("busy did not rise after the first key press");
    end
    kbd = dir_to_kbd(second);
    next_cycle();
    kbd = 4'b0000;
    while (busy) begin
      next_cycle();
    end
  endtask

  // expected position on open floor, edges stop the step
  task automatic step_model(input player_pkg::dir_t d);
    case (d)
      player_pkg::dir_left: begin
        if (exp_x != 4'd0) exp_x = exp_x - 4'd1;
      end
      player_pkg::dir_right: begin
        if (exp_x != tile_pkg::coord_t'(`GRID_W - 1)) exp_x = exp_x + 4'd1;
      end
      player_pkg::dir_up: begin
        if (exp_y != 4'd0) exp_y = exp_y - 4'd1;
      end
      player_pkg::dir_down: begin
        if (exp_y != tile_pkg::coord_t'(`GRID_W - 1)) exp_y = exp_y + 4'd1;
      end
      default: begin
      end
    endcase
  endtask

  task automatic step_and_check(input player_pkg::dir_t d);
    step_model(d);
    press(d);
    check_position(exp_x, exp_y);
  endtask

  task automatic reset_and_moves();
    player_pkg::dir_t d;
    int unsigned      r;
    check_position(exp_x, exp_y);
    check_health(health, player_pkg::health_t'(`INIT_HEALTH));
    check_keys(key_num, 8'd0);
    check_floor(floor, 2'd0);
    step_and_check(player_pkg::dir_left);
    step_and_check(player_pkg::dir_left);
    step_and_check(player_pkg::dir_up);
    step_and_check(player_pkg::dir_up);
    repeat (16) begin
      r = $urandom % 4;
      case (r)
        0:       d = player_pkg::dir_left;
        1:       d = player_pkg::dir_down;
        2:       d = player_pkg::dir_up;
        default: d = player_pkg::dir_right;
      endcase
      step_and_check(d);
    end
    // walk into the right and bottom edges
    apply_reset();
    repeat (`GRID_W) step_and_check(player_pkg::dir_right);
    repeat (`GRID_W) step_and_check(player_pkg::dir_down);
  endtask

  task automatic wall_and_key();
    apply_reset();
    load_cell(2'd0, 4'd2, 4'd1, tile_pkg::tile_wall);
    press(player_pkg::dir_right);
    check_position(4'd1, 4'd1);
    load_cell(2'd0, 4'd1, 4'd2, tile_pkg::tile_key);
    press(player_pkg::dir_down);
    check_position(4'd1, 4'd2);
    check_keys(key_num, 8'd1);
    press(player_pkg::dir_up);
    check_position(4'd1, 4'd1);
    press(player_pkg::dir_down);
    check_position(4'd1, 4'd2);
    check_keys(key_num, 8'd1);
    load_cell(2'd0, 4'd2, 4'd1, tile_pkg::tile_floor);
  endtask

  task automatic door_rules();
    apply_reset();
    load_cell(2'd0, 4'd0, 4'd1, tile_pkg::tile_door);
    press(player_pkg::dir_left);
    check_position(4'd1, 4'd1);
    check_keys(key_num, 8'd0);
    load_cell(2'd0, 4'd1, 4'd0, tile_pkg::tile_key);
    press(player_pkg::dir_up);
    check_position(4'd1, 4'd0);
    check_keys(key_num, 8'd1);
    press(player_pkg::dir_down);
    press(player_pkg::dir_left);
    check_position(4'd0, 4'd1);
    check_keys(key_num, 8'd0);
    // opened door is plain floor now
    press(player_pkg::dir_right);
    press(player_pkg::dir_left);
    check_position(4'd0, 4'd1);
    check_keys(key_num, 8'd0);
  endtask

  task automatic monster_fights();
    player_pkg::health_t exp_h;
    apply_reset();
    exp_h = player_pkg::health_t'(`INIT_HEALTH);
    repeat (4) begin
      load_cell(2'd0, 4'd2, 4'd1, tile_pkg::tile_monster);
      press(player_pkg::dir_right);
      if (exp_h > player_pkg::health_t'(`MONSTER_DAMAGE)) begin
        exp_h = exp_h - player_pkg::health_t'(`MONSTER_DAMAGE);
        check_position(4'd2, 4'd1);
        check_health(health, exp_h);
        press(player_pkg::dir_left);
      end else begin
        check_position(4'd1, 4'd1);
        check_health(health, exp_h);
      end
    end
    load_cell(2'd0, 4'd2, 4'd1, tile_pkg::tile_floor);
  endtask

  task automatic stairs_climb();
    player_pkg::floor_t fl;
    player_pkg::floor_t top;
    apply_reset();
    top = player_pkg::floor_t'(`FLOORS - 1);
    for (int f = 0; f < `FLOORS; f++) begin
      fl = player_pkg::floor_t'(f);
      load_cell(fl, 4'd2, 4'd1, tile_pkg::tile_stairs);
      press(player_pkg::dir_right);
      check_position(4'd1, 4'd1);
      if (f < `FLOORS - 1) begin
        check_floor(floor, player_pkg::floor_t'(f + 1));
      end else begin
        check_floor(floor, top);
      end
    end
    // only the top floor's tiles count now
    load_cell(top, 4'd1, 4'd2, tile_pkg::tile_wall);
    load_cell(2'd0, 4'd1, 4'd0, tile_pkg::tile_wall);
    press(player_pkg::dir_down);
    check_position(4'd1, 4'd1);
    press(player_pkg::dir_up);
    check_position(4'd1, 4'd0);
    for (int f = 0; f < `FLOORS; f++) begin
      load_cell(player_pkg::floor_t'(f), 4'd2, 4'd1, tile_pkg::tile_floor);
    end
    load_cell(top, 4'd1, 4'd2, tile_pkg::tile_floor);
    load_cell(2'd0, 4'd1, 4'd0, tile_pkg::tile_floor);
  endtask

  task automatic priority_and_busy();
    apply_reset();
    press_keys(dir_to_kbd(player_pkg::dir_left) | dir_to_kbd(player_pkg::dir_right));
    check_position(4'd0, 4'd1);
    press_keys(dir_to_kbd(player_pkg::dir_down) | dir_to_kbd(player_pkg::dir_up));
    check_position(4'd0, 4'd2);
    press_keys(dir_to_kbd(player_pkg::dir_up) | dir_to_kbd(player_pkg::dir_right));
    check_position(4'd0, 4'd1);
    press_during_busy(player_pkg::dir_right, player_pkg::dir_down);
    check_position(4'd1, 4'd1);
    repeat (4) next_cycle();
    check_position(4'd1, 4'd1);
  endtask

  initial begin
    rst_n     = 1'b0;
    kbd       = 4'b0000;
    load_we   = 1'b0;
    load_addr = '0;
    load_tile = tile_pkg::tile_floor;
    void'($urandom(32'h6e));
    next_cycle();
    apply_reset();
    clear_map();
    reset_and_moves();
    wall_and_key();
    door_rules();
    monster_fights();
    stairs_climb();
    priority_and_busy();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tower.f
+incdir+.
tile_pkg.sv
player_pkg.sv
move_decode.sv
tile_interact.sv
player_stats.sv
map_ram.sv
tower_core.sv
tb_clock.sv
tower_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tower_tb
FILELIST  ?= tower.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
